//--- hdl/dram_bridge_macros.svh
/* dram bridge parameters
   data width, block size, address field widths, FIFO depth and
   read latency of the channel model */

`ifndef DRAM_BRIDGE_MACROS_SVH
`define DRAM_BRIDGE_MACROS_SVH

`define DATA_W      32
`define BLOCK_WORDS 4

// address fields
`define BA_W 2
`define BG_W 2
`define RO_W 4
`define CO_W 4
`define BO_W 2

`define FIFO_DEPTH 4
`define READ_LAT   3

`endif

//--- hdl/dram_bridge_pkg.sv
/* dram bridge types
   address layouts in cache and DRAM order, DMA packet,
   DRAM request and read response */

`include "dram_bridge_macros.svh"

package dram_bridge_pkg;

  // order used by the cache DMA
  typedef struct packed {
    logic [`BA_W-1:0] ba;
    logic [`BG_W-1:0] bg;
    logic [`RO_W-1:0] ro;
    logic [`CO_W-1:0] co;
    logic [`BO_W-1:0] bo;
  } cache_ch_addr_t;

  // order used by the DRAM channel
  typedef struct packed {
    logic [`RO_W-1:0] ro;
    logic [`BG_W-1:0] bg;
    logic [`BA_W-1:0] ba;
    logic [`CO_W-1:0] co;
    logic [`BO_W-1:0] bo;
  } dram_ch_addr_t;

  typedef struct packed {
    logic           write_not_read;
    cache_ch_addr_t addr;
  } dma_pkt_t;

  typedef struct packed {
    logic                write_not_read;
    cache_ch_addr_t      addr;
    logic [`DATA_W-1:0]  data;
  } dram_req_t;

  typedef struct packed {
    cache_ch_addr_t     addr;
    logic [`DATA_W-1:0] data;
  } dram_rsp_t;

endpackage

//--- hdl/dma_req_issuer.sv
/* DMA request issuer
   accepts one DMA packet and splits the block into per-word DRAM
   requests, taking write data beats as they arrive */

`timescale 1ns/1ns

`include "dram_bridge_macros.svh"

module dma_req_issuer
  import dram_bridge_pkg::*;
  (
    input                       clk_i
    , input                     rst_i

    , input  dma_pkt_t          dma_pkt_i
    , input                     dma_pkt_v_i
    , output logic              dma_pkt_yumi_o

    , input  [`DATA_W-1:0]      dma_data_i
    , input                     dma_data_v_i
    , output logic              dma_data_ready_o

    , output dram_req_t         req_o
    , output logic              req_v_o
    , input                     req_ready_i
  );

  localparam int CNT_W = $clog2(`BLOCK_WORDS);

  typedef enum logic [1:0] {e_idle, e_write, e_read} state_e;

  state_e           state_r;
  dma_pkt_t         pkt_r;
  logic [CNT_W-1:0] cnt_r;
  logic             req_fire;
  logic             last_word;

  assign dma_pkt_yumi_o   = ~rst_i & (state_r == e_idle) & dma_pkt_v_i;
  assign dma_data_ready_o = (state_r == e_write) & req_ready_i;

  // writes follow the data beats, reads go out back to back
  assign req_v_o   = ((state_r == e_write) & dma_data_v_i) | (state_r == e_read);
  assign req_fire  = req_v_o & req_ready_i;
  assign last_word = (cnt_r == CNT_W'(`BLOCK_WORDS - 1));

  // word index replaces the low column bits
  always_comb begin
    req_o.write_not_read = pkt_r.write_not_read;
    req_o.addr           = pkt_r.addr;
    req_o.addr.co        = {pkt_r.addr.co[`CO_W-1:CNT_W], cnt_r};
    req_o.addr.bo        = '0;
    req_o.data           = (state_r == e_write) ? dma_data_i : '0;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_r <= e_idle;
      cnt_r   <= '0;
    end else begin
      case (state_r)
        e_idle: begin
          if (dma_pkt_v_i) begin
            state_r <= dma_pkt_i.write_not_read ? e_write : e_read;
          end
        end
        default: begin
          if (req_fire) begin
            cnt_r <= last_word ? '0 : cnt_r + 1'b1;
            if (last_word) begin
              state_r <= e_idle;
            end
          end
        end
      endcase
    end
  end

  // held for the whole block
  always_ff @(posedge clk_i) begin
    if (dma_pkt_yumi_o) begin
      pkt_r <= dma_pkt_i;
    end
  end

endmodule

//--- hdl/dram_fifo.sv
/* valid/yumi FIFO
   circular buffer with a type-parameterized payload, takes a push
   and a pop in the same cycle even when full */

`timescale 1ns/1ns

`include "dram_bridge_macros.svh"

module dram_fifo
  #(parameter type payload_t = logic)
  (
    input                clk_i
    , input              rst_i

    , input  payload_t   data_i
    , input              v_i
    , output logic       ready_o

    , output payload_t   data_o
    , output logic       v_o
    , input              yumi_i
  );

  localparam int PTR_W = $clog2(`FIFO_DEPTH);
  localparam int CNT_W = $clog2(`FIFO_DEPTH + 1);

  payload_t         mem_r [`FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_r;
  logic [PTR_W-1:0] rd_ptr_r;
  logic [CNT_W-1:0] count_r;
  logic             full;
  logic             wr_en;

  assign full    = (count_r == CNT_W'(`FIFO_DEPTH));
  assign ready_o = ~full | yumi_i;
  assign wr_en   = v_i & ready_o;
  assign v_o     = (count_r != '0);
  assign data_o  = mem_r[rd_ptr_r];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_r <= (wr_ptr_r == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : wr_ptr_r + 1'b1;
      end
      if (yumi_i) begin
        rd_ptr_r <= (rd_ptr_r == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : rd_ptr_r + 1'b1;
      end
      // count only moves on a lone push or pop
      case ({wr_en, yumi_i})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem_r[wr_ptr_r] <= data_i;
    end
  end

endmodule

//--- hdl/dram_channel_model.sv
/* DRAM channel model
   reorders cache addresses into row-bankgroup-bank order, stores words
   and returns reads through a fixed-latency pipeline with global stall */

`timescale 1ns/1ns

`include "dram_bridge_macros.svh"

module dram_channel_model
  import dram_bridge_pkg::*;
  (
    input                clk_i
    , input              rst_i

    , input  dram_req_t  req_i
    , input              req_v_i
    , output logic       req_yumi_o

    , output dram_rsp_t  rsp_o
    , output logic       rsp_v_o
    , input              rsp_ready_i
  );

  localparam int MEM_AW    = `RO_W + `BG_W + `BA_W + `CO_W;
  localparam int MEM_WORDS = 1 << MEM_AW;

  dram_ch_addr_t        req_dram_addr;
  dram_ch_addr_t        done_addr;
  logic [MEM_AW-1:0]    mem_idx;
  logic [`DATA_W-1:0]   mem_r [MEM_WORDS];
  logic                 stall;
  logic [`READ_LAT-1:0] pipe_v_r;
  logic [`DATA_W-1:0]   pipe_data_r [`READ_LAT];
  dram_ch_addr_t        pipe_addr_r [`READ_LAT];

  // cache order in, DRAM order out
  always_comb begin
    req_dram_addr.ro = req_i.addr.ro;
    req_dram_addr.bg = req_i.addr.bg;
    req_dram_addr.ba = req_i.addr.ba;
    req_dram_addr.co = req_i.addr.co;
    req_dram_addr.bo = req_i.addr.bo;
  end

  // word index drops the byte offset
  assign mem_idx = {req_dram_addr.ro, req_dram_addr.bg, req_dram_addr.ba, req_dram_addr.co};

  // freeze everything while the oldest read cannot leave
  assign stall      = pipe_v_r[`READ_LAT-1] & ~rsp_ready_i;
  assign req_yumi_o = req_v_i & ~stall;

  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem_r[i] = '0;
    end
  end

  always @(posedge clk_i) begin
    if (req_yumi_o & req_i.write_not_read) begin
      mem_r[mem_idx] <= req_i.data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pipe_v_r <= '0;
    end else if (~stall) begin
      pipe_v_r <= {pipe_v_r[`READ_LAT-2:0], req_yumi_o & ~req_i.write_not_read};
    end
  end

  always_ff @(posedge clk_i) begin
    if (~stall) begin
      pipe_data_r[0] <= mem_r[mem_idx];
      pipe_addr_r[0] <= req_dram_addr;
      for (int i = 1; i < `READ_LAT; i++) begin
        pipe_data_r[i] <= pipe_data_r[i-1];
        pipe_addr_r[i] <= pipe_addr_r[i-1];
      end
    end
  end

  assign done_addr = pipe_addr_r[`READ_LAT-1];
  assign rsp_v_o   = pipe_v_r[`READ_LAT-1];

  // read-done address back to cache order
  always_comb begin
    rsp_o.addr.ba = done_addr.ba;
    rsp_o.addr.bg = done_addr.bg;
    rsp_o.addr.ro = done_addr.ro;
    rsp_o.addr.co = done_addr.co;
    rsp_o.addr.bo = done_addr.bo;
    rsp_o.data    = pipe_data_r[`READ_LAT-1];
  end

endmodule

//--- hdl/dram_bridge_top.sv
/* DRAM channel bridge
   DMA issuer feeding a request FIFO into the channel model, with
   read words returned through a response FIFO */

`timescale 1ns/1ns

`include "dram_bridge_macros.svh"

module dram_bridge_top
  import dram_bridge_pkg::*;
  (
    input                       clk_i
    , input                     rst_i

    , input  dma_pkt_t          dma_pkt_i
    , input                     dma_pkt_v_i
    , output logic              dma_pkt_yumi_o

    , input  [`DATA_W-1:0]      dma_data_i
    , input                     dma_data_v_i
    , output logic              dma_data_ready_o

    , output dram_rsp_t         dma_rsp_o
    , output logic              dma_rsp_v_o
    , input                     dma_rsp_ready_i
  );

  dram_req_t iss_req;
  logic      iss_req_v;
  logic      req_fifo_ready;
  dram_req_t fifo_req;
  logic      fifo_req_v;
  logic      model_yumi;
  dram_rsp_t model_rsp;
  logic      model_rsp_v;
  logic      rsp_fifo_ready;
  logic      rsp_yumi;

  dma_req_issuer issuer (
    .clk_i(clk_i)
    ,.rst_i(rst_i)
    ,.dma_pkt_i(dma_pkt_i)
    ,.dma_pkt_v_i(dma_pkt_v_i)
    ,.dma_pkt_yumi_o(dma_pkt_yumi_o)
    ,.dma_data_i(dma_data_i)
    ,.dma_data_v_i(dma_data_v_i)
    ,.dma_data_ready_o(dma_data_ready_o)
    ,.req_o(iss_req)
    ,.req_v_o(iss_req_v)
    ,.req_ready_i(req_fifo_ready)
  );

  dram_fifo #(.payload_t(dram_req_t)) req_fifo (
    .clk_i(clk_i)
    ,.rst_i(rst_i)
    ,.data_i(iss_req)
    ,.v_i(iss_req_v)
    ,.ready_o(req_fifo_ready)
    ,.data_o(fifo_req)
    ,.v_o(fifo_req_v)
    ,.yumi_i(model_yumi)
  );

  dram_channel_model channel (
    .clk_i(clk_i)
    ,.rst_i(rst_i)
    ,.req_i(fifo_req)
    ,.req_v_i(fifo_req_v)
    ,.req_yumi_o(model_yumi)
    ,.rsp_o(model_rsp)
    ,.rsp_v_o(model_rsp_v)
    ,.rsp_ready_i(rsp_fifo_ready)
  );

  // ready/valid on the outside, yumi toward the FIFO
  assign rsp_yumi = dma_rsp_v_o & dma_rsp_ready_i;

  dram_fifo #(.payload_t(dram_rsp_t)) rsp_fifo (
    .clk_i(clk_i)
    ,.rst_i(rst_i)
    ,.data_i(model_rsp)
    ,.v_i(model_rsp_v)
    ,.ready_o(rsp_fifo_ready)
    ,.data_o(dma_rsp_o)
    ,.v_o(dma_rsp_v_o)
    ,.yumi_i(rsp_yumi)
  );

endmodule

//--- tests/dram_bridge_tb.sv
/* DRAM channel bridge testbench
   random write and read blocks checked against a reference word
   memory, with gaps on write data and back-pressure on responses */

`timescale 1ns/1ns

`include "dram_bridge_macros.svh"

module dram_bridge_tb
  import dram_bridge_pkg::*;
  ();

  localparam int WAIT_LIMIT = 2000;
  localparam int WORD_BITS  = $clog2(`BLOCK_WORDS);
  localparam int REF_AW     = `BA_W + `BG_W + `RO_W + `CO_W;
  localparam int EXP_DEPTH  = 256;

  logic               clk_i;
  logic               rst_i;
  dma_pkt_t           dma_pkt_i;
  logic               dma_pkt_v_i;
  logic               dma_pkt_yumi_o;
  logic [`DATA_W-1:0] dma_data_i;
  logic               dma_data_v_i;
  logic               dma_data_ready_o;
  dram_rsp_t          dma_rsp_o;
  logic               dma_rsp_v_o;
  logic               dma_rsp_ready_i;

  integer             seed = 32'he125;
  logic [1:0]         ready_mode = 2'd0;
  logic               rst_q = 1'b0;
  logic               stalled_q = 1'b0;
  dram_rsp_t          rsp_q;
  logic               rsp_fire;
  logic [`DATA_W-1:0] ref_mem [1 << REF_AW];
  cache_ch_addr_t     exp_addr_q [EXP_DEPTH];
  logic [`DATA_W-1:0] exp_data_q [EXP_DEPTH];
  int                 exp_wr_idx = 0;
  int                 exp_rd_idx = 0;
  cache_ch_addr_t     exp_addr;
  logic [`DATA_W-1:0] exp_data;

  dram_bridge_top dram_bridge_top_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("sim failed");
    $fatal(1, "run stopped");
  endtask

  // word i of a block: low column bits replaced, byte offset cleared
  function automatic cache_ch_addr_t word_addr(input cache_ch_addr_t base, input int i);
    cache_ch_addr_t a;
    a = base;
    a.co[WORD_BITS-1:0] = i[WORD_BITS-1:0];
    a.bo = '0;
    return a;
  endfunction

  function automatic logic [REF_AW-1:0] ref_index(input cache_ch_addr_t a);
    return {a.ba, a.bg, a.ro, a.co};
  endfunction

  assign rsp_fire = dma_rsp_v_o & dma_rsp_ready_i;
  assign exp_addr = exp_addr_q[exp_rd_idx % EXP_DEPTH];
  assign exp_data = exp_data_q[exp_rd_idx % EXP_DEPTH];

  always @(posedge clk_i) begin
    rst_q     <= rst_i;
    stalled_q <= dma_rsp_v_o & ~dma_rsp_ready_i;
    rsp_q     <= dma_rsp_o;
    if (rsp_fire) begin
      exp_rd_idx <= exp_rd_idx + 1;
    end
  end

  // quiet outputs during reset and the cycle after
  reset_pkt_yumi: assert property (@(posedge clk_i) rst_q |-> !dma_pkt_yumi_o)
    else abort_run($sformatf("[ERROR] dma_pkt_yumi_o expected %h actual %h",
                             1'b0, $sampled(dma_pkt_yumi_o)));
  reset_data_ready: assert property (@(posedge clk_i) rst_q |-> !dma_data_ready_o)
    else abort_run($sformatf("[ERROR] dma_data_ready_o expected %h actual %h",
                             1'b0, $sampled(dma_data_ready_o)));
  reset_rsp_v: assert property (@(posedge clk_i) rst_q |-> !dma_rsp_v_o)
    else abort_run($sformatf("[ERROR] dma_rsp_v_o expected %h actual %h",
                             1'b0, $sampled(dma_rsp_v_o)));

  rsp_outstanding: assert property (@(posedge clk_i) dma_rsp_v_o |-> exp_wr_idx != exp_rd_idx)
    else abort_run("a read response came out with no read outstanding");
  rsp_addr_match: assert property (@(posedge clk_i) rsp_fire |-> dma_rsp_o.addr == exp_addr)
    else abort_run($sformatf("[ERROR] dma_rsp_o.addr expected %h actual %h",
                             $sampled(exp_addr), $sampled(dma_rsp_o.addr)));
  rsp_data_match: assert property (@(posedge clk_i) rsp_fire |-> dma_rsp_o.data == exp_data)
    else abort_run($sformatf("[ERROR] dma_rsp_o.data expected %h actual %h",
                             $sampled(exp_data), $sampled(dma_rsp_o.data)));
  rsp_hold_valid: assert property (@(posedge clk_i) stalled_q |-> dma_rsp_v_o)
    else abort_run("dma_rsp_v_o dropped while dma_rsp_ready_i was low");
  rsp_hold_value: assert property (@(posedge clk_i) stalled_q |-> dma_rsp_o == rsp_q)
    else abort_run($sformatf("[ERROR] dma_rsp_o expected %h actual %h",
                             $sampled(rsp_q), $sampled(dma_rsp_o)));

  // drawn at the falling edge, applied after the rising one
  initial begin : ready_driver
    logic next_ready;
    forever begin
      @(negedge clk_i);
      case (ready_mode)
        2'd0:    next_ready = 1'b1;
        2'd1:    next_ready = ($random(seed) % 4) != 0;
        default: next_ready = ($random(seed) % 8) == 0;
      endcase
      @(posedge clk_i);
      #1 dma_rsp_ready_i = next_ready;
    end
  end

  task automatic send_pkt(input logic wnr, input cache_ch_addr_t addr);
    int waited;
    waited = 0;
    dma_pkt_i.write_not_read = wnr;
    dma_pkt_i.addr = addr;
    dma_pkt_v_i = 1'b1;
    @(negedge clk_i);
    while (!dma_pkt_yumi_o) begin
      waited++;
      if (waited > WAIT_LIMIT) abort_run("timeout waiting for the packet to be accepted");
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1 dma_pkt_v_i = 1'b0;
  endtask

  task automatic write_block(input cache_ch_addr_t base);
    int   beat;
    int   waited;
    logic fired;
    beat = 0;
    waited = 0;
    send_pkt(1'b1, base);
    while (beat < `BLOCK_WORDS) begin
      // a raised valid stays up until the beat transfers
      if (!dma_data_v_i && ($random(seed) % 3) != 0) begin
        dma_data_i   = $random(seed);
        dma_data_v_i = 1'b1;
      end
      @(negedge clk_i);
      fired = dma_data_v_i & dma_data_ready_o;
      if (fired) begin
        ref_mem[ref_index(word_addr(base, beat))] = dma_data_i;
        beat++;
        waited = 0;
      end else begin
        waited++;
        if (waited > WAIT_LIMIT) abort_run("timeout waiting for a write beat to transfer");
      end
      @(posedge clk_i);
      #1;
      if (fired) dma_data_v_i = 1'b0;
    end
  endtask

  task automatic read_block(input cache_ch_addr_t base);
    cache_ch_addr_t a;
    for (int i = 0; i < `BLOCK_WORDS; i++) begin
      a = word_addr(base, i);
      exp_addr_q[exp_wr_idx % EXP_DEPTH] = a;
      exp_data_q[exp_wr_idx % EXP_DEPTH] = ref_mem[ref_index(a)];
      exp_wr_idx++;
    end
    send_pkt(1'b0, base);
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    @(negedge clk_i);
    while (exp_rd_idx != exp_wr_idx) begin
      waited++;
      if (waited > WAIT_LIMIT) abort_run("timeout waiting for all read responses");
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
  endtask

  initial begin : stimulus
    cache_ch_addr_t a;
    cache_ch_addr_t blk [6];
    logic [31:0]    r;
    rst_i           = 1'b1;
    dma_pkt_i       = '0;
    // a packet offered during reset must not be taken
    dma_pkt_v_i     = 1'b1;
    dma_data_i      = '0;
    dma_data_v_i    = 1'b0;
    dma_rsp_ready_i = 1'b0;
    for (int i = 0; i < (1 << REF_AW); i++) ref_mem[i] = '0;
    repeat (5) @(posedge clk_i);
    #1;
    rst_i       = 1'b0;
    dma_pkt_v_i = 1'b0;
    @(posedge clk_i);
    #1;

    // read straight after write, then two writes before a read
    r = $random(seed);
    a = r[$bits(cache_ch_addr_t)-1:0];
    write_block(a);
    read_block(a);
    write_block(a);
    write_block(a);
    read_block(a);
    wait_drained();

    ready_mode = 2'd1;
    repeat (6) begin
      r = $random(seed);
      a = r[$bits(cache_ch_addr_t)-1:0];
      write_block(a);
      read_block(a);
    end
    wait_drained();

    // same column and offset, banks and rows differ
    for (int i = 0; i < 6; i++) begin
      blk[i] = '{ba: i[1:0], bg: 2'd1, ro: 4'(3 * i + 1), co: 4'd9, bo: 2'd3};
      write_block(blk[i]);
    end
    ready_mode = 2'd2;
    for (int i = 0; i < 6; i++) read_block(blk[i]);
    wait_drained();

    $display("sim passed");
    $finish;
  end

endmodule

//--- dram_bridge.f
+incdir+hdl
hdl/dram_bridge_pkg.sv
hdl/dma_req_issuer.sv
hdl/dram_fifo.sv
hdl/dram_channel_model.sv
hdl/dram_bridge_top.sv
tests/dram_bridge_tb.sv
